// ==== chiplet_rx_endpoint.f ====
logic/chiplet_types_pkg.sv
logic/rx_cfg_pkg.sv
logic/rx_crc.sv
logic/packet_buffer.sv
logic/commit_fifo.sv
logic/rx_fsm.sv
logic/chiplet_rx_endpoint.sv
bench/tb_chiplet_rx_endpoint.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the receive endpoint testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_chiplet_rx_endpoint
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" \
    -f chiplet_rx_endpoint.f --Mdir obj_dir -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
exit 0

// ==== bench/tb_chiplet_rx_endpoint.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_chiplet_rx_endpoint;
    import chiplet_types_pkg::*;
    import rx_cfg_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_RAND   = 20;

    typedef logic [PKT_LENGTH_WIDTH-1:0] length_t;

    logic      clk = 1'b0;
    logic      n_rst, flit_valid, desc_pop, desc_valid, crc_error, dropped;
    word_t     flit_data, rd_data;
    buf_addr_t rd_addr, desc_start;
    length_t   desc_length;
    node_id_t  desc_src, req;

    integer seed = 97400;
    int     errors, packets, commits, crc_errs, drops, err_pulses, drop_pulses;
    longint limit_ns;

    // expected descriptors packed as {start, length, src}
    logic [BUF_ADDR_WIDTH+PKT_LENGTH_WIDTH+3:0] exp_q[$];
    int        exp_count;
    buf_addr_t exp_start, exp_wr;
    length_t   exp_len;
    node_id_t  exp_src;
    word_t     payload[128];

    // random packets are drawn up front so the watchdog can be sized
    bit       r_long[NUM_RAND], r_bad[NUM_RAND], r_pop[NUM_RAND];
    int       r_len[NUM_RAND], r_gap[NUM_RAND];
    node_id_t r_src[NUM_RAND];

    chiplet_rx_endpoint dut_i (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    always @(posedge clk) begin
        if (crc_error) err_pulses <= err_pulses + 1;
        if (dropped) drop_pulses <= drop_pulses + 1;
    end

    valid_ok: assert property (@(posedge clk) disable iff (!n_rst)
        desc_valid == (exp_count != 0))
        else begin
            $display("Error: desc_valid got %h expected %h",
                     $sampled(desc_valid), $sampled(exp_count != 0));
            errors++;
        end
    start_ok: assert property (@(posedge clk) disable iff (!n_rst)
        desc_valid |-> desc_start == exp_start)
        else begin
            $display("Error: desc_start got %h expected %h", $sampled(desc_start), exp_start);
            errors++;
        end
    length_ok: assert property (@(posedge clk) disable iff (!n_rst)
        desc_valid |-> desc_length == exp_len)
        else begin
            $display("Error: desc_length got %h expected %h", $sampled(desc_length), exp_len);
            errors++;
        end
    src_ok: assert property (@(posedge clk) disable iff (!n_rst)
        desc_valid |-> desc_src == exp_src)
        else begin
            $display("Error: desc_src got %h expected %h", $sampled(desc_src), exp_src);
            errors++;
        end

    // crc-32 taken msb first with no reflection and no final inversion
    function automatic word_t crc_next(input word_t crc_in, input word_t word);
        word_t crc;
        logic  fb;
        crc = crc_in;
        for (int b = 31; b >= 0; b--) begin
            fb  = crc[31] ^ word[b];
            crc = {crc[30:0], 1'b0} ^ (fb ? CRC_POLY : 32'h0);
        end
        return crc;
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // dst, tag and reserved bits stay random
    function automatic word_t make_header(input bit is_long, input node_id_t src, input int len);
        word_t hdr;
        hdr        = $random(seed);
        hdr[31]    = is_long;
        hdr[30:27] = src;
        if (is_long) hdr[22:16] = len[6:0];
        else hdr[22:20] = len[2:0];
        return hdr;
    endfunction

    function automatic void refresh_head();
        exp_count = exp_q.size();
        if (exp_count != 0) {exp_start, exp_len, exp_src} = exp_q[0];
    endfunction

    task automatic read_back(input buf_addr_t start, input int len);
        for (int i = 0; i <= len; i++) begin
            @(posedge clk);
            rd_addr <= start + buf_addr_t'(i);
            @(negedge clk);
            if (i > 0) begin
                assert (rd_data == payload[i-1]) else begin
                    $display("Error: rd_data at %h got %h expected %h",
                             start + buf_addr_t'(i - 1), rd_data, payload[i-1]);
                    errors++;
                end
            end
        end
    endtask

    // header, payload, crc flit, then two quiet cycles for the commit
    task automatic send_packet(input bit is_long, input node_id_t src, input int len,
                               input bit bad);
        word_t     crc;
        bit        full_at_hdr;
        buf_addr_t start;
        full_at_hdr = (exp_count == FIFO_DEPTH);
        start       = exp_wr;
        crc         = CRC_INIT;
        packets++;
        @(posedge clk);
        flit_valid <= 1'b1;
        flit_data  <= make_header(is_long, src, len);
        for (int i = 0; i < len; i++) begin
            payload[i] = $random(seed);
            crc        = crc_next(crc, payload[i]);
            @(posedge clk);
            flit_data <= payload[i];
        end
        if (bad) crc = crc ^ (word_t'(1) << rand_below(32));
        @(posedge clk);
        flit_data <= crc;
        @(posedge clk);
        flit_valid <= 1'b0;
        flit_data  <= $random(seed);
        @(posedge clk);
        @(negedge clk);
        if (full_at_hdr) begin
            drops++;
        end else if (bad) begin
            crc_errs++;
        end else begin
            commits++;
            exp_q.push_back({start, length_t'(len), src});
            exp_wr = start + buf_addr_t'(len);
            refresh_head();
            assert (req == src) else begin
                $display("Error: req got %h expected %h", req, src);
                errors++;
            end
        end
        assert (err_pulses == crc_errs) else begin
            $display("Error: crc_error pulses got %h expected %h", err_pulses, crc_errs);
            errors++;
        end
        assert (drop_pulses == drops) else begin
            $display("Error: dropped pulses got %h expected %h", drop_pulses, drops);
            errors++;
        end
        if (!full_at_hdr && !bad) read_back(start, len);
    endtask

    task automatic pop_desc();
        bit had;
        had = (exp_count != 0);
        @(posedge clk);
        desc_pop <= 1'b1;
        @(posedge clk);
        desc_pop <= 1'b0;
        @(negedge clk);
        if (had) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    endtask

    task automatic drain_fifo();
        while (exp_count != 0) pop_desc();
    endtask

    task automatic report_test(input int num, input string name, input int err_mark);
        $display("test %0d %s: %0d new errors", num, name, errors - err_mark);
    endtask

    initial begin : watchdog
        wait (limit_ns > 0);
        #(limit_ns);
        $display("timeout: run still busy after %0d ns", limit_ns);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int cycles;
        int err_mark;
        n_rst      = 1'b0;
        flit_valid = 1'b0;
        flit_data  = '0;
        desc_pop   = 1'b0;
        rd_addr    = '0;
        exp_wr     = '0;
        // the fixed tests send 11 packets with 86 payload flits
        cycles = 8 + 86 + 11 * 10;
        for (int i = 0; i < NUM_RAND; i++) begin
            r_long[i] = bit'(rand_below(2));
            r_len[i]  = r_long[i] ? rand_below(41) : rand_below(8);
            r_src[i]  = node_id_t'(rand_below(16));
            r_bad[i]  = (rand_below(4) == 0);
            r_gap[i]  = rand_below(4);
            r_pop[i]  = bit'(rand_below(2));
            cycles    = cycles + r_len[i] + r_gap[i] + 10;
        end
        limit_ns = longint'(cycles) * CLK_PERIOD * 4;
        repeat (8) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        assert (req == 4'h0) else begin
            $display("Error: req after reset got %h expected %h", req, 4'h0);
            errors++;
        end
        assert (!desc_valid) else begin
            $display("Error: desc_valid after reset got %h expected %h", desc_valid, 1'b0);
            errors++;
        end

        err_mark = errors;
        send_packet(1'b0, 4'h3, 5, 1'b0);
        drain_fifo();
        report_test(1, "short packet", err_mark);

        err_mark = errors;
        send_packet(1'b1, 4'h9, 40, 1'b0);
        drain_fifo();
        report_test(2, "long packet", err_mark);

        err_mark = errors;
        send_packet(1'b0, 4'h5, 6, 1'b1);
        send_packet(1'b1, 4'h7, 12, 1'b0);
        drain_fifo();
        report_test(3, "bad crc rewind", err_mark);

        // fifth packet meets a full FIFO
        err_mark = errors;
        for (int i = 0; i < 5; i++) send_packet(1'b0, node_id_t'(i + 1), 4, 1'b0);
        drain_fifo();
        send_packet(1'b0, 4'h2, 3, 1'b0);
        drain_fifo();
        report_test(4, "full FIFO drop", err_mark);

        err_mark = errors;
        send_packet(1'b0, 4'hA, 0, 1'b0);
        drain_fifo();
        report_test(5, "zero length", err_mark);

        err_mark = errors;
        for (int i = 0; i < NUM_RAND; i++) begin
            send_packet(r_long[i], r_src[i], r_len[i], r_bad[i]);
            if (r_pop[i]) pop_desc();
            repeat (r_gap[i]) @(negedge clk);
        end
        drain_fifo();
        report_test(6, "random traffic", err_mark);

        $display("packets %0d, committed %0d, crc errors %0d, dropped %0d, errors %0d",
                 packets, commits, crc_errs, drops, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/chiplet_rx_endpoint.sv ====
`default_nettype none
`timescale 1ns/1ps

module chiplet_rx_endpoint (
    input  logic                                            clk,
    input  logic                                            n_rst,
    input  logic                                            flit_valid,
    input  chiplet_types_pkg::word_t                        flit_data,
    input  logic                                            desc_pop,
    input  rx_cfg_pkg::buf_addr_t                           rd_addr,
    output logic                                            desc_valid,
    output rx_cfg_pkg::buf_addr_t                           desc_start,
    output logic [chiplet_types_pkg::PKT_LENGTH_WIDTH-1:0]  desc_length,
    output chiplet_types_pkg::node_id_t                     desc_src,
    output chiplet_types_pkg::word_t                        rd_data,
    output chiplet_types_pkg::node_id_t                     req,
    output logic                                            crc_error,
    output logic                                            dropped
);
    import chiplet_types_pkg::*;
    import rx_cfg_pkg::*;

    logic                        crc_clear, crc_enable;
    word_t                       crc_val;
    logic                        wr_enable;
    buf_addr_t                   wr_addr;
    logic                        fifo_push, full;
    buf_addr_t                   push_start;
    logic [PKT_LENGTH_WIDTH-1:0] push_length;
    node_id_t                    push_src;

    rx_fsm fsm_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .flit_valid  (flit_valid),
        .flit_data   (flit_data),
        .crc_val     (crc_val),
        .full        (full),
        .crc_clear   (crc_clear),
        .crc_enable  (crc_enable),
        .wr_enable   (wr_enable),
        .wr_addr     (wr_addr),
        .fifo_push   (fifo_push),
        .push_start  (push_start),
        .push_length (push_length),
        .push_src    (push_src),
        .req         (req),
        .crc_error   (crc_error),
        .dropped     (dropped)
    );

    // payload flits feed the checker and the buffer in parallel
    rx_crc crc_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .crc_clear  (crc_clear),
        .crc_enable (crc_enable),
        .data       (flit_data),
        .crc_val    (crc_val)
    );

    packet_buffer buf_i (
        .clk       (clk),
        .wr_enable (wr_enable),
        .wr_addr   (wr_addr),
        .rd_addr   (rd_addr),
        .wr_data   (flit_data),
        .rd_data   (rd_data)
    );

    commit_fifo fifo_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .push        (fifo_push),
        .pop         (desc_pop),
        .push_start  (push_start),
        .push_length (push_length),
        .push_src    (push_src),
        .full        (full),
        .not_empty   (desc_valid),
        .head_start  (desc_start),
        .head_length (desc_length),
        .head_src    (desc_src)
    );

endmodule

`default_nettype wire

// ==== logic/rx_fsm.sv ====
`default_nettype none
`timescale 1ns/1ps

module rx_fsm (
    input  logic                                            clk,
    input  logic                                            n_rst,
    input  logic                                            flit_valid,
    input  chiplet_types_pkg::word_t                        flit_data,
    input  chiplet_types_pkg::word_t                        crc_val,
    input  logic                                            full,
    output logic                                            crc_clear,
    output logic                                            crc_enable,
    output logic                                            wr_enable,
    output rx_cfg_pkg::buf_addr_t                           wr_addr,
    output logic                                            fifo_push,
    output rx_cfg_pkg::buf_addr_t                           push_start,
    output logic [chiplet_types_pkg::PKT_LENGTH_WIDTH-1:0]  push_length,
    output chiplet_types_pkg::node_id_t                     push_src,
    output chiplet_types_pkg::node_id_t                     req,
    output logic                                            crc_error,
    output logic                                            dropped
);
    import chiplet_types_pkg::*;
    import rx_cfg_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        GET_LENGTH,
        CRC_CHECK,
        REQ_EN,
        DROP
    } state_e;

    typedef logic [PKT_LENGTH_WIDTH-1:0] length_t;

    state_e    state, next_state;
    hdr_u      hdr_q;
    length_t   count, next_count;
    length_t   hdr_len, pkt_len;
    buf_addr_t pkt_start, next_wr_addr;
    node_id_t  pkt_src, next_req;
    logic      hdr_take, next_crc_error, next_dropped;

    // length of an incoming header and of the latched one
    assign hdr_len  = expected_num_flits(flit_data);
    assign pkt_len  = expected_num_flits(hdr_q);
    // source field sits at the same bits in both formats
    assign pkt_src  = hdr_q.long_hdr.src;
    assign hdr_take = (state == IDLE) && flit_valid;

    // descriptor of the packet being committed
    assign push_start  = pkt_start;
    assign push_length = pkt_len;
    assign push_src    = pkt_src;

    always_comb begin
        next_state     = state;
        next_count     = count;
        next_wr_addr   = wr_addr;
        next_req       = req;
        next_crc_error = 1'b0;
        next_dropped   = 1'b0;
        crc_clear      = 1'b0;
        crc_enable     = 1'b0;
        wr_enable      = 1'b0;
        fifo_push      = 1'b0;
        case (state)
            IDLE: begin
                if (flit_valid) begin
                    crc_clear  = 1'b1;
                    next_count = '0;
                    if (full) begin
                        next_state = DROP;
                    end else if (hdr_len == '0) begin
                        next_state = CRC_CHECK;
                    end else begin
                        next_state = GET_LENGTH;
                    end
                end
            end
            GET_LENGTH: begin
                if (flit_valid) begin
                    wr_enable    = 1'b1;
                    crc_enable   = 1'b1;
                    next_wr_addr = wr_addr + 1'b1;
                    next_count   = count + 1'b1;
                    if (count + 1'b1 == pkt_len) begin
                        next_state = CRC_CHECK;
                    end
                end
            end
            CRC_CHECK: begin
                if (flit_valid) begin
                    if (flit_data == crc_val) begin
                        next_state = REQ_EN;
                    end else begin
                        // throw the payload away by rewinding
                        next_crc_error = 1'b1;
                        next_wr_addr   = pkt_start;
                        next_state     = IDLE;
                    end
                end
            end
            REQ_EN: begin
                fifo_push  = 1'b1;
                next_req   = pkt_src;
                next_state = IDLE;
            end
            DROP: begin
                // consumes the payload and the crc flit without writing
                if (flit_valid) begin
                    if (count == pkt_len) begin
                        next_dropped = 1'b1;
                        next_state   = IDLE;
                    end else begin
                        next_count = count + 1'b1;
                    end
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state     <= IDLE;
            count     <= '0;
            wr_addr   <= '0;
            req       <= '0;
            crc_error <= 1'b0;
            dropped   <= 1'b0;
        end else begin
            state     <= next_state;
            count     <= next_count;
            wr_addr   <= next_wr_addr;
            req       <= next_req;
            crc_error <= next_crc_error;
            dropped   <= next_dropped;
        end
    end

    // header and start address of the open packet
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            hdr_q     <= flit_data;
            pkt_start <= wr_addr;
        end
    end

    count_in_range: assert property (@(posedge clk) disable iff (!n_rst)
        (state != IDLE) |-> (count <= pkt_len))
        else $error("payload counter %0d past length %0d", count, pkt_len);

    // room was checked at the header and only this block pushes
    push_has_room: assert property (@(posedge clk) disable iff (!n_rst)
        $rose(fifo_push) |-> !full)
        else $error("commit pushed into a full FIFO");

endmodule

`default_nettype wire

// ==== logic/commit_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module commit_fifo (
    input  logic                                            clk,
    input  logic                                            n_rst,
    input  logic                                            push,
    input  logic                                            pop,
    input  rx_cfg_pkg::buf_addr_t                           push_start,
    input  logic [chiplet_types_pkg::PKT_LENGTH_WIDTH-1:0]  push_length,
    input  chiplet_types_pkg::node_id_t                     push_src,
    output logic                                            full,
    output logic                                            not_empty,
    output rx_cfg_pkg::buf_addr_t                           head_start,
    output logic [chiplet_types_pkg::PKT_LENGTH_WIDTH-1:0]  head_length,
    output chiplet_types_pkg::node_id_t                     head_src
);
    import chiplet_types_pkg::*;
    import rx_cfg_pkg::*;

    buf_addr_t                   start_mem  [FIFO_DEPTH];
    logic [PKT_LENGTH_WIDTH-1:0] length_mem [FIFO_DEPTH];
    node_id_t                    src_mem    [FIFO_DEPTH];

    logic [FIFO_PTR_WIDTH-1:0]   wr_ptr, rd_ptr;
    logic [FIFO_COUNT_WIDTH-1:0] count;
    logic                        do_push, do_pop;

    assign full      = (count == FIFO_DEPTH);
    assign not_empty = (count != '0);
    assign do_push   = push && !full;
    // pop on an empty queue has no effect
    assign do_pop    = pop && not_empty;

    assign head_start  = start_mem[rd_ptr];
    assign head_length = length_mem[rd_ptr];
    assign head_src    = src_mem[rd_ptr];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            start_mem[wr_ptr]  <= push_start;
            length_mem[wr_ptr] <= push_length;
            src_mem[wr_ptr]    <= push_src;
        end
    end

    count_bounded: assert property (@(posedge clk) disable iff (!n_rst)
        count <= FIFO_DEPTH)
        else $error("descriptor count %0d above depth", count);

endmodule

`default_nettype wire

// ==== logic/packet_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

module packet_buffer (
    input  logic                     clk,
    input  logic                     wr_enable,
    input  rx_cfg_pkg::buf_addr_t    wr_addr,
    input  rx_cfg_pkg::buf_addr_t    rd_addr,
    input  chiplet_types_pkg::word_t wr_data,
    output chiplet_types_pkg::word_t rd_data
);
    import chiplet_types_pkg::*;
    import rx_cfg_pkg::*;

    // payload storage, wraps with the write address
    word_t mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_enable) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, one cycle of latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== logic/rx_crc.sv ====
`default_nettype none
`timescale 1ns/1ps

module rx_crc (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     crc_clear,
    input  logic                     crc_enable,
    input  chiplet_types_pkg::word_t data,
    output chiplet_types_pkg::word_t crc_val
);
    import chiplet_types_pkg::*;
    import rx_cfg_pkg::*;

    // one word folded in bit by bit, msb first
    function automatic word_t crc_word(input word_t crc_in, input word_t word);
        word_t crc;
        logic  fb;
        crc = crc_in;
        for (int i = $bits(word_t) - 1; i >= 0; i--) begin
            fb  = crc[31] ^ word[i];
            crc = {crc[30:0], 1'b0};
            if (fb) begin
                crc = crc ^ CRC_POLY;
            end
        end
        return crc;
    endfunction

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc_val <= CRC_INIT;
        end else if (crc_clear) begin
            crc_val <= CRC_INIT;
        end else if (crc_enable) begin
            crc_val <= crc_word(crc_val, data);
        end
    end

    // a header never coincides with a payload flit
    clear_xor_enable: assert property (@(posedge clk) disable iff (!n_rst)
        !(crc_clear && crc_enable))
        else $error("crc clear and enable together");

endmodule

`default_nettype wire

// ==== logic/rx_cfg_pkg.sv ====
`default_nettype none

package rx_cfg_pkg;

    // circular packet buffer
    localparam int BUF_ADDR_WIDTH = 8;
    localparam int BUF_DEPTH      = 1 << BUF_ADDR_WIDTH;

    typedef logic [BUF_ADDR_WIDTH-1:0] buf_addr_t;

    // commit FIFO of packet descriptors
    localparam int FIFO_DEPTH       = 4;
    localparam int FIFO_PTR_WIDTH   = $clog2(FIFO_DEPTH);
    localparam int FIFO_COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    // CRC-32, msb first, no reflection, no final xor
    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// ==== logic/chiplet_types_pkg.sv ====
`default_nettype none

package chiplet_types_pkg;

    // one flit on the switch link
    typedef logic [31:0] word_t;

    // chiplet node number
    typedef logic [3:0] node_id_t;

    // payload length in flits, long format is the widest
    localparam int PKT_LENGTH_WIDTH = 7;

    // short header, format bit clear
    typedef struct packed {
        logic       fmt;
        node_id_t   src;
        node_id_t   dst;
        logic [2:0] length;
        logic [19:0] rsvd;
    } short_hdr_t;

    // long header, format bit set
    typedef struct packed {
        logic                        fmt;
        node_id_t                    src;
        node_id_t                    dst;
        logic [PKT_LENGTH_WIDTH-1:0] length;
        logic [15:0]                 tag;
    } long_hdr_t;

    // first flit of a packet, read through whichever view fmt selects
    typedef union packed {
        short_hdr_t short_hdr;
        long_hdr_t  long_hdr;
    } hdr_u;

    // payload flits announced by a header word
    function automatic logic [PKT_LENGTH_WIDTH-1:0] expected_num_flits(input word_t flit);
        hdr_u hdr;
        hdr = flit;
        if (hdr.long_hdr.fmt) begin
            return hdr.long_hdr.length;
        end
        // short length is zero extended
        return {{(PKT_LENGTH_WIDTH-3){1'b0}}, hdr.short_hdr.length};
    endfunction

endpackage

`default_nettype wire
